// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    localparam int xlen = 32;
    localparam logic [4:0] reg_ra = 5'd31;

    // primary opcodes sit in instr[31:26].
    localparam logic [5:0] op_rtype  = 6'h00;
    localparam logic [5:0] op_regimm = 6'h01;
    localparam logic [5:0] op_j      = 6'h02;
    localparam logic [5:0] op_jal    = 6'h03;
    localparam logic [5:0] op_beq    = 6'h04;
    localparam logic [5:0] op_bne    = 6'h05;
    localparam logic [5:0] op_blez   = 6'h06;
    localparam logic [5:0] op_bgtz   = 6'h07;
    localparam logic [5:0] op_addi   = 6'h08;
    localparam logic [5:0] op_addiu  = 6'h09;
    localparam logic [5:0] op_slti   = 6'h0a;
    localparam logic [5:0] op_andi   = 6'h0c;
    localparam logic [5:0] op_ori    = 6'h0d;
    localparam logic [5:0] op_xori   = 6'h0e;
    localparam logic [5:0] op_lui    = 6'h0f;
    localparam logic [5:0] op_lw     = 6'h23;
    localparam logic [5:0] op_sw     = 6'h2b;

    // function codes of the R-type group sit in instr[5:0].
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_sllv    = 6'h04;
    localparam logic [5:0] fn_srlv    = 6'h06;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_and    = 4'd2;
    localparam logic [3:0] alu_or     = 4'd3;
    localparam logic [3:0] alu_xor    = 4'd4;
    localparam logic [3:0] alu_nor    = 4'd5;
    localparam logic [3:0] alu_slt    = 4'd6;
    localparam logic [3:0] alu_sll    = 4'd7;
    localparam logic [3:0] alu_srl    = 4'd8;
    localparam logic [3:0] alu_sra    = 4'd9;
    localparam logic [3:0] alu_lui    = 4'd10;
    localparam logic [3:0] alu_pass_a = 4'd11;

    // one instruction word seen in its three encodings.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_t;

endpackage

// ==== rtl/alu_controller.sv ====
`timescale 1ns/100ps

module alu_controller import mips_pkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] func,
    output logic [3:0] alu_operation
);

    always_comb begin
        alu_operation = alu_add;
        if (opcode == op_rtype) begin
            case (func)
                fn_add, fn_addu:  alu_operation = alu_add;
                fn_sub, fn_subu:  alu_operation = alu_sub;
                fn_and:           alu_operation = alu_and;
                fn_or:            alu_operation = alu_or;
                fn_xor:           alu_operation = alu_xor;
                fn_nor:           alu_operation = alu_nor;
                fn_slt:           alu_operation = alu_slt;
                fn_sll, fn_sllv:  alu_operation = alu_sll;
                fn_srl, fn_srlv:  alu_operation = alu_srl;
                fn_sra:           alu_operation = alu_sra;
                fn_jr:            alu_operation = alu_pass_a;
                default:          alu_operation = alu_add;
            endcase
        end else begin
            case (opcode)
                op_lw, op_sw, op_addi, op_addiu: alu_operation = alu_add;
                op_slti:                         alu_operation = alu_slt;
                op_andi:                         alu_operation = alu_and;
                op_ori:                          alu_operation = alu_or;
                op_xori:                         alu_operation = alu_xor;
                op_lui:                          alu_operation = alu_lui;
                op_beq, op_bne:                  alu_operation = alu_sub;
                // single-operand branches look at rs alone.
                op_blez, op_bgtz, op_regimm:     alu_operation = alu_pass_a;
                default:                         alu_operation = alu_add;
            endcase
        end
    end

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps

module control_unit import mips_pkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] func,
    input  logic       zero,
    input  logic       negative,
    output logic       halted,
    output logic       alu_src,
    output logic       reg_dest,
    output logic       pc_or_mem,
    output logic       mem_or_reg,
    output logic       branch,
    output logic       jump_register,
    output logic       jump,
    output logic       is_unsigned,
    output logic       reg_write_enable,
    output logic       does_shift_amount_need,
    output logic       mem_write_en,
    output logic [3:0] alu_operation
);

    logic should_branch;

    alu_controller alu_controller_i (
        .opcode        (opcode),
        .func          (func),
        .alu_operation (alu_operation)
    );

    always_comb begin
        halted                 = 1'b0;
        alu_src                = 1'b0;
        reg_dest               = 1'b0;
        pc_or_mem              = 1'b0;
        mem_or_reg             = 1'b0;
        jump_register          = 1'b0;
        jump                   = 1'b0;
        is_unsigned            = 1'b0;
        reg_write_enable       = 1'b0;
        does_shift_amount_need = 1'b0;
        mem_write_en           = 1'b0;
        should_branch          = 1'b0;
        case (opcode)
            op_rtype: begin
                case (func)
                    fn_syscall: halted = 1'b1;
                    fn_jr:      jump_register = 1'b1;
                    fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                    fn_slt, fn_sllv, fn_srlv: begin
                        reg_dest         = 1'b1;
                        reg_write_enable = 1'b1;
                    end
                    fn_sll, fn_srl, fn_sra: begin
                        reg_dest               = 1'b1;
                        reg_write_enable       = 1'b1;
                        does_shift_amount_need = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            op_addi, op_addiu, op_slti, op_lui: begin
                reg_write_enable = 1'b1;
                alu_src          = 1'b1;
            end
            op_andi, op_ori, op_xori: begin
                reg_write_enable = 1'b1;
                alu_src          = 1'b1;
                is_unsigned      = 1'b1;
            end
            op_beq, op_bne, op_blez, op_bgtz, op_regimm: begin
                should_branch = 1'b1;
            end
            op_j: jump = 1'b1;
            op_jal: begin
                pc_or_mem        = 1'b1;
                reg_write_enable = 1'b1;
                jump             = 1'b1;
            end
            op_lw: begin
                mem_or_reg       = 1'b1;
                alu_src          = 1'b1;
                reg_write_enable = 1'b1;
            end
            op_sw: begin
                alu_src      = 1'b1;
                mem_write_en = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // flags come from rs-rt for beq/bne and from rs itself otherwise.
    always_comb begin
        branch = 1'b0;
        if (should_branch) begin
            case (opcode)
                op_beq:    branch = zero;
                op_bne:    branch = ~zero;
                op_blez:   branch = zero | negative;
                op_bgtz:   branch = ~zero & ~negative;
                op_regimm: branch = ~negative;
                default:   branch = 1'b0;
            endcase
        end
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu import mips_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [4:0]      shamt,
    input  logic [3:0]      alu_operation,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            negative
);

    logic signed_less;

    assign signed_less = $signed(a) < $signed(b);

    always_comb begin
        case (alu_operation)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_nor:    result = ~(a | b);
            alu_slt:    result = {{(xlen-1){1'b0}}, signed_less};
            alu_sll:    result = b << shamt;
            alu_srl:    result = b >> shamt;
            alu_sra:    result = $signed(b) >>> shamt;
            // lui only needs the low half of b moved up.
            alu_lui:    result = {b[15:0], 16'h0000};
            alu_pass_a: result = a;
            default:    result = a + b;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[xlen-1];

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/100ps

module register_file import mips_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs_addr,
    input  logic [4:0]      rt_addr,
    output logic [xlen-1:0] rs_data,
    output logic [xlen-1:0] rt_data,
    input  logic            wr_en,
    input  logic [4:0]      wr_addr,
    input  logic [xlen-1:0] wr_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 is never written, so it always reads back as zero.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

// ==== rtl/mips_core.sv ====
`timescale 1ns/100ps

module mips_core import mips_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output logic [xlen-1:0] instr_addr,
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] data_addr,
    output logic [xlen-1:0] data_wdata,
    input  logic [xlen-1:0] data_rdata,
    output logic            data_we,
    output logic            halted
);

    instr_t          ir;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic            halt_q;
    logic            syscall_hit;
    logic            alu_src;
    logic            reg_dest;
    logic            pc_or_mem;
    logic            mem_or_reg;
    logic            branch;
    logic            jump_register;
    logic            jump;
    logic            is_unsigned;
    logic            reg_write_enable;
    logic            does_shift_amount_need;
    logic            mem_write_en;
    logic [3:0]      alu_operation;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] imm_sext;
    logic [xlen-1:0] alu_b;
    logic [4:0]      shift_amount;
    logic [xlen-1:0] alu_result;
    logic            alu_zero;
    logic            alu_negative;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;

    assign ir = instr;

    control_unit control_unit_i (
        .opcode                 (ir.r.opcode),
        .func                   (ir.r.funct),
        .zero                   (alu_zero),
        .negative               (alu_negative),
        .halted                 (syscall_hit),
        .alu_src                (alu_src),
        .reg_dest               (reg_dest),
        .pc_or_mem              (pc_or_mem),
        .mem_or_reg             (mem_or_reg),
        .branch                 (branch),
        .jump_register          (jump_register),
        .jump                   (jump),
        .is_unsigned            (is_unsigned),
        .reg_write_enable       (reg_write_enable),
        .does_shift_amount_need (does_shift_amount_need),
        .mem_write_en           (mem_write_en),
        .alu_operation          (alu_operation)
    );

    register_file register_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (ir.r.rs),
        .rt_addr (ir.r.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (reg_write_enable & ~halt_q),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    assign imm_sext = {{(xlen-16){ir.i.imm[15]}}, ir.i.imm};
    assign imm_ext  = is_unsigned ? {{(xlen-16){1'b0}}, ir.i.imm} : imm_sext;
    assign alu_b    = alu_src ? imm_ext : rt_data;

    // variable shifts take their amount from rs.
    assign shift_amount = does_shift_amount_need ? ir.r.shamt : rs_data[4:0];

    alu alu_i (
        .a             (rs_data),
        .b             (alu_b),
        .shamt         (shift_amount),
        .alu_operation (alu_operation),
        .result        (alu_result),
        .zero          (alu_zero),
        .negative      (alu_negative)
    );

    assign pc_plus4 = pc + 32'd4;

    assign wr_addr = pc_or_mem ? reg_ra : (reg_dest ? ir.r.rd : ir.r.rt);
    assign wr_data = pc_or_mem ? pc_plus4 : (mem_or_reg ? data_rdata : alu_result);

    always_comb begin
        if (jump_register) begin
            next_pc = rs_data;
        end else if (jump) begin
            next_pc = {pc_plus4[xlen-1:28], ir.j.target, 2'b00};
        end else if (branch) begin
            next_pc = pc_plus4 + {imm_sext[xlen-3:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

    // once syscall is seen the PC stays on it until reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            halt_q <= 1'b0;
        end else begin
            halt_q <= halt_q | syscall_hit;
            if (!halt_q && !syscall_hit) begin
                pc <= next_pc;
            end
        end
    end

    assign instr_addr = pc;
    assign data_addr  = alu_result;
    assign data_wdata = rt_data;
    assign data_we    = mem_write_en & ~halt_q;
    assign halted     = halt_q;

endmodule

// ==== tests/mips_core_properties.sv ====
`timescale 1ns/100ps

module mips_core_properties import mips_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic [xlen-1:0] instr_addr,
    input logic [xlen-1:0] data_addr,
    input logic            data_we,
    input logic            halted
);

    // a halted core leaves data memory alone.
    no_store_when_halted: assert property (
        @(posedge clk) disable iff (!arst_n) halted |-> !data_we
    ) else $error("data_we is high while the core is halted");

    pc_frozen_when_halted: assert property (
        @(posedge clk) disable iff (!arst_n) halted |=> $stable(instr_addr)
    ) else $error("instr_addr moved while the core is halted");

    store_addr_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
            data_we |-> (!$isunknown(data_addr) && data_addr[1:0] == 2'b00)
    ) else $error("store to an unaligned or unknown address");

endmodule

bind mips_core mips_core_properties mips_core_properties_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .data_addr  (data_addr),
    .data_we    (data_we),
    .halted     (halted)
);

// ==== tests/mips_core_tb.sv ====
`timescale 1ns/100ps

module mips_core_tb import mips_pkg::*; ();

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] instr_addr;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] data_addr;
    logic [xlen-1:0] data_wdata;
    logic [xlen-1:0] data_rdata;
    logic            data_we;
    logic            halted;

    logic [xlen-1:0] imem [64];
    logic [xlen-1:0] dmem [64];
    logic [xlen-1:0] expected_q [$];
    logic [31:0]     lfsr;
    string           current_test;
    int              prog_len;
    int              error_count;
    int              test_errors;
    int              test_count;
    int              check_count;

    mips_core dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_we    (data_we),
        .halted     (halted)
    );

    // both memories answer in the same cycle and are indexed by word.
    assign instr      = imem[instr_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (arst_n && data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic instr_t r_format(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] shamt);
        instr_t w;
        w.r = '{op_rtype, rs, rt, rd, shamt, funct};
        return w;
    endfunction

    function automatic instr_t i_format(logic [5:0] opcode, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
        instr_t w;
        w.i = '{opcode, rs, rt, imm};
        return w;
    endfunction

    function automatic instr_t j_format(logic [5:0] opcode, logic [25:0] target);
        instr_t w;
        w.j = '{opcode, target};
        return w;
    endfunction

    function automatic logic [31:0] fill_word(int i);
        return 32'hfeed0000 | 32'(i << 2);
    endfunction

    // expected results follow the MIPS definitions of each R-type operation.
    function automatic logic [31:0] r_expect(logic [5:0] funct, logic [31:0] s, logic [31:0] t,
                                             logic [4:0] sh);
        case (funct)
            fn_add, fn_addu: return s + t;
            fn_sub, fn_subu: return s - t;
            fn_and:          return s & t;
            fn_or:           return s | t;
            fn_xor:          return s ^ t;
            fn_nor:          return ~(s | t);
            fn_slt:          return ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
            fn_sll:          return t << sh;
            fn_srl:          return t >> sh;
            fn_sra:          return $signed(t) >>> sh;
            fn_sllv:         return t << s[4:0];
            fn_srlv:         return t >> s[4:0];
            default:         return 'x;
        endcase
    endfunction

    function automatic logic [31:0] i_expect(logic [5:0] opcode, logic [31:0] s,
                                             logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        sx = {{16{imm[15]}}, imm};
        zx = {16'h0000, imm};
        case (opcode)
            op_addi, op_addiu: return s + sx;
            op_andi:           return s & zx;
            op_ori:            return s | zx;
            op_xori:           return s ^ zx;
            op_slti:           return ($signed(s) < $signed(sx)) ? 32'd1 : 32'd0;
            op_lui:            return {imm, 16'h0000};
            default:           return 'x;
        endcase
    endfunction

    task automatic check_word(string what, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", current_test, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_bit(string what, logic expected, logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %b, actual %b", current_test, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 64; i++) begin
            imem[i] = i_format(op_ori, 5'd0, 5'd0, 16'(i));
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic emit(instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // results go to word 16 onward with one slot per store.
    task automatic emit_store(logic [4:0] src, logic [31:0] expected);
        emit(i_format(op_sw, 5'd0, src, 16'(64 + 4 * expected_q.size())));
        expected_q.push_back(expected);
    endtask

    task automatic begin_test(string name);
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        current_test = name;
        test_errors = 0;
        prog_len = 0;
        expected_q.delete();
        clear_memories();
    endtask

    task automatic run_program();
        int cycles;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < 500) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("%s: the core did not halt within 500 cycles", current_test);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        foreach (expected_q[k]) begin
            check_word($sformatf("slot %0d", k), expected_q[k], dmem[16 + k]);
        end
        check_bit("halted", 1'b1, halted);
        test_count++;
        if (test_errors == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            $display("test %s: %0d errors", current_test, test_errors);
        end
    endtask

    task automatic test_arith_logic();
        logic [5:0]  fns [9];
        logic [5:0]  ops [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        fns = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt};
        ops = '{op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti};
        begin_test("arith_logic");
        a = random_bits(32);
        b = random_bits(32);
        dmem[0] = a;
        dmem[1] = b;
        emit(i_format(op_lw, 5'd0, 5'd1, 16'h0000));
        emit(i_format(op_lw, 5'd0, 5'd2, 16'h0004));
        foreach (fns[k]) begin
            emit(r_format(fns[k], 5'd1, 5'd2, 5'd3, 5'd0));
            emit_store(5'd3, r_expect(fns[k], a, b, 5'd0));
        end
        // a set top bit tells zero extension apart from sign extension.
        foreach (ops[k]) begin
            imm = 16'(random_bits(16)) | 16'h8000;
            emit(i_format(ops[k], 5'd1, 5'd3, imm));
            emit_store(5'd3, i_expect(ops[k], a, imm));
        end
        emit(r_format(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        run_program();
        finish_test();
    endtask

    task automatic test_shifts();
        logic [5:0]  fns [5];
        logic [31:0] v;
        logic [31:0] amt;
        logic [4:0]  sh;
        logic [15:0] imm;
        fns = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv};
        begin_test("shifts_lui");
        v = random_bits(32) | 32'h80000000;
        amt = random_bits(5) | 32'd1;
        dmem[0] = v;
        dmem[1] = amt;
        emit(i_format(op_lw, 5'd0, 5'd1, 16'h0000));
        emit(i_format(op_lw, 5'd0, 5'd2, 16'h0004));
        foreach (fns[k]) begin
            sh = 5'(random_bits(4) + 1);
            emit(r_format(fns[k], 5'd2, 5'd1, 5'd3, sh));
            emit_store(5'd3, r_expect(fns[k], amt, v, sh));
        end
        imm = 16'(random_bits(16));
        emit(i_format(op_lui, 5'd0, 5'd3, imm));
        emit_store(5'd3, i_expect(op_lui, 32'd0, imm));
        emit(r_format(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        run_program();
        finish_test();
    endtask

    task automatic test_memory();
        logic [31:0] v;
        begin_test("memory");
        v = random_bits(32);
        dmem[0] = v;
        emit(i_format(op_lw, 5'd0, 5'd1, 16'h0000));
        emit(i_format(op_addi, 5'd0, 5'd4, 16'h0020));
        // base 0x20 plus offset 8 lands on word 10.
        emit(i_format(op_sw, 5'd4, 5'd1, 16'h0008));
        emit(i_format(op_lw, 5'd4, 5'd3, 16'h0008));
        emit_store(5'd3, v);
        emit(r_format(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        run_program();
        check_word("stored word", v, dmem[10]);
        finish_test();
    endtask

    task automatic test_branches();
        logic [5:0] bop [10];
        logic [4:0] brs [10];
        logic [4:0] brt [10];
        bit         taken [10];
        bop = '{op_beq, op_beq, op_bne, op_bne, op_blez, op_blez, op_bgtz, op_bgtz,
                op_regimm, op_regimm};
        brs = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd0, 5'd0, 5'd2};
        brt = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd0, 5'd0, 5'd0, 5'd0, 5'd1, 5'd1};
        taken = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        begin_test("branches");
        dmem[0] = random_bits(31) | 32'd1;
        dmem[1] = random_bits(32) | 32'h80000000;
        emit(i_format(op_lw, 5'd0, 5'd1, 16'h0000));
        emit(i_format(op_lw, 5'd0, 5'd2, 16'h0004));
        emit(i_format(op_ori, 5'd0, 5'd3, 16'h5a5a));
        // a taken branch skips the marker store behind it.
        foreach (bop[k]) begin
            emit(i_format(bop[k], brs[k], brt[k], 16'h0001));
            emit_store(5'd3, taken[k] ? fill_word(16 + expected_q.size()) : 32'h00005a5a);
        end
        emit(r_format(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        run_program();
        finish_test();
    endtask

    task automatic test_jumps();
        logic [31:0] jal_addr;
        begin_test("jumps");
        emit(i_format(op_ori, 5'd0, 5'd3, 16'h5a5a));
        emit(j_format(op_j, 26'(prog_len + 2)));
        emit_store(5'd3, fill_word(16));
        jal_addr = 32'(4 * prog_len);
        emit(j_format(op_jal, 26'(prog_len + 3)));
        emit_store(reg_ra, jal_addr + 32'd4);
        emit(r_format(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(r_format(fn_jr, reg_ra, 5'd0, 5'd0, 5'd0));
        run_program();
        finish_test();
    endtask

    task automatic test_halt();
        logic [31:0] halt_addr;
        begin_test("halt");
        emit(i_format(op_ori, 5'd0, 5'd3, 16'h1234));
        halt_addr = 32'(4 * prog_len);
        emit(r_format(fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        emit_store(5'd3, fill_word(16));
        run_program();
        check_word("pc at halt", halt_addr, instr_addr);
        repeat (10) @(posedge clk);
        #1;
        check_word("pc after halt", halt_addr, instr_addr);
        check_bit("halted later", 1'b1, halted);
        finish_test();
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        test_count = 0;
        lfsr = 32'h1529327a;
        arst_n = 1'b0;
        clear_memories();
        test_arith_logic();
        test_shifts();
        test_memory();
        test_branches();
        test_jumps();
        test_halt();
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/mips_pkg.sv
rtl/alu_controller.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/register_file.sv
rtl/mips_core.sv
tests/mips_core_properties.sv
tests/mips_core_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module mips_core_tb -o Vmips_core_tb
	./obj_dir/Vmips_core_tb | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module mips_core_tb

clean:
	rm -rf obj_dir $(LOG)
